/* design/divSqrtPkg.sv */
// Shared types for the iterative divide and square root unit
// Operands are unsigned integers only, there is no signed or float support
// The special kinds cover only the cases that finish without iterating

package divSqrtPkg;

  //////////////////////////////
  // Operation select
  //////////////////////////////

  // One bit is enough since the unit does only two operations
  typedef enum logic [0:0] {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } opT;

  //////////////////////////////
  // Special case kinds
  //////////////////////////////

  // A zero dividend wins over a zero divisor for division
  typedef enum logic [1:0] {
    SPC_NONE    = 2'd0,
    SPC_ZERO    = 2'd1,
    SPC_DIVZERO = 2'd2
  } specialT;

endpackage

/* design/divSqrtIf.sv */
// Launch bundle between the producer, the control FSM and the iteration buffer
// The producer fields are combinational from the operands and only meaningful
// in the cycle where launch is high
// The counter width must match the local counters of the FSM and the buffer

`timescale 1ns/1ps

interface divSqrtIf #(
  parameter int WIDTH = 16
);

  // Cycle counts go up to WIDTH so one extra value is needed
  localparam int CNT_W = $clog2(WIDTH + 1);

  // Operand capture strobe from the FSM
  logic                  launch;
  // Operation and special kind worked out by the producer
  divSqrtPkg::opT        op;
  divSqrtPkg::specialT   special;
  // Number of radix-2 steps the operation needs
  logic [CNT_W-1:0]      cycles;
  // Dividend shifted so the first step sees its top significant bit
  logic [WIDTH-1:0]      normX;
  // Divisor for division, zero for square root
  logic [WIDTH-1:0]      normY;

  // Producer drives the operand fields and sees the launch strobe
  modport pre  (output op, special, cycles, normX, normY, input launch);
  // Control only needs to know how long to stay busy
  modport ctl  (output launch, input special, cycles);
  // The buffer loads everything at launch
  modport iter (input launch, op, special, cycles, normX, normY);

endinterface

/* design/divSqrtPreproc.sv */
// Producer stage, purely combinational from x, y and sqrt
// WIDTH must be even and between 8 and 32, since square root pairs the
// dividend bits starting at the LSB
// A zero x is special for both operations, a zero y only for division
// The special kind is not held here, the consumer registers it at launch

`timescale 1ns/1ps

module divSqrtPreproc #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  input  logic             sqrt,
  divSqrtIf.pre            link
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  // Leading zeros and significant bits of the dividend
  logic [CNT_W-1:0] lz;
  logic [CNT_W-1:0] sigBits;
  // Square root shift is lz rounded down to an even count
  logic [CNT_W-1:0] sqrtShift;
  // One extra bit so the round up never wraps
  logic [CNT_W:0]   halfUp;

  // Odd widths would leave the top bit without a partner
  if ((WIDTH % 2) != 0 || WIDTH < 8 || WIDTH > 32) begin : gBadWidth
    $error("divSqrtPreproc needs an even WIDTH from 8 to 32");
  end

  //////////////////////////////
  // Leading zero count
  //////////////////////////////

  // Scan upward so the highest set bit makes the last assignment
  always_comb begin
    lz = CNT_W'(WIDTH);
    for (int i = 0; i < WIDTH; i++) begin
      if (x[i]) lz = CNT_W'(WIDTH - 1 - i);
    end
  end

  assign sigBits   = CNT_W'(WIDTH) - lz;
  assign sqrtShift = {lz[CNT_W-1:1], 1'b0};
  assign halfUp    = ({1'b0, sigBits} + 1'b1) >> 1;

  //////////////////////////////
  // Classification and normalization
  //////////////////////////////

  always_comb begin
    link.op = sqrt ? divSqrtPkg::OP_SQRT : divSqrtPkg::OP_DIV;
    // Zero dividend first, it also covers 0/0
    if (x == '0)               link.special = divSqrtPkg::SPC_ZERO;
    else if (!sqrt && y == '0) link.special = divSqrtPkg::SPC_DIVZERO;
    else                       link.special = divSqrtPkg::SPC_NONE;
    if (sqrt) begin
      // Two bits per step, half the significant bits rounded up
      link.cycles = halfUp[CNT_W-1:0];
      link.normX  = x << sqrtShift;
      link.normY  = '0;
    end else begin
      // One quotient bit per significant dividend bit
      link.cycles = sigBits;
      link.normX  = x << lz;
      link.normY  = y;
    end
  end

  // A normal launch with a zero count would leave the FSM stuck in BUSY
  always_comb begin
    if (link.launch && link.special == divSqrtPkg::SPC_NONE) begin
      assert (link.cycles != '0)
        else $error("normal launch with zero cycle count");
    end
  end

endmodule

/* design/divSqrtFsm.sv */
// Control FSM for one operation at a time that steps through IDLE, BUSY and DONE
// Special cases skip BUSY and reach DONE one edge after launch
// Stall blocks a new launch and holds DONE
// Flush returns to IDLE from any state
// Busy covers the launch cycle too, so it is high from launch until done

`timescale 1ns/1ps

module divSqrtFsm #(
  parameter int WIDTH = 16
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  stall,
  input  logic  flush,
  divSqrtIf.ctl link,
  output logic  busy,
  output logic  done
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } stateT;

  stateT            state;
  // Remaining BUSY cycles as loaded from the producer count
  logic [CNT_W-1:0] step;
  logic             isSpecial;

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Operands are only taken here when the unit is idle and not stalled
  assign link.launch = start & (state == IDLE) & ~stall;
  assign isSpecial   = (link.special != divSqrtPkg::SPC_NONE);
  assign busy        = (state == BUSY) | link.launch;
  assign done        = (state == DONE);

  //////////////////////////////
  // State and step counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | flush) begin
      state <= IDLE;
      step  <= '0;
    end else if (link.launch) begin
      step  <= link.cycles;
      // Special cases have a fixed result and need no steps
      state <= isSpecial ? DONE : BUSY;
    end else if (state == BUSY) begin
      // The buffer does its last step in the same cycle that step is one
      if (step == CNT_W'(1)) state <= DONE;
      step <= step - 1'b1;
    end else if (state == DONE) begin
      // Result stays presented until the consumer side lets go
      if (!stall) state <= IDLE;
    end
  end

  // An accepted launch always leaves IDLE unless flushed in the same cycle
  launchLeavesIdle: assert property (
    @(posedge clk) disable iff (rst)
    link.launch && !flush |=> state != IDLE
  );

  // A zero count from the producer would wrap the counter and hang in BUSY
  stepNonZero: assert property (
    @(posedge clk) disable iff (rst)
    state == BUSY |-> step != '0
  );

endmodule

/* design/divSqrtIter.sv */
// Iteration buffer, one radix-2 step per busy cycle after launch
// Division is restoring, square root is digit by digit on bit pairs
// The quotient and remainder outputs are the values the current step writes,
// so they are only meaningful while finish is high
// Payload registers have no reset, only the step counter does

`timescale 1ns/1ps

module divSqrtIter #(
  parameter int WIDTH = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              busy,
  divSqrtIf.iter            link,
  output logic [WIDTH-1:0]  quotient,
  output logic [WIDTH-1:0]  remainder,
  output logic              finish
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  // Partial remainder needs one bit above the operand width
  logic [WIDTH:0]   remReg;
  logic [WIDTH:0]   remNext;
  // Shifted dividend, divisor and quotient or root bits
  logic [WIDTH-1:0] dvdReg;
  logic [WIDTH-1:0] dvdNext;
  logic [WIDTH-1:0] dvsReg;
  logic [WIDTH-1:0] quoReg;
  logic [WIDTH-1:0] quoNext;
  divSqrtPkg::opT   opReg;
  logic [CNT_W-1:0] cnt;
  logic             step;
  // Trial operands and their difference with a sign bit
  logic [WIDTH:0]   trialRem;
  logic [WIDTH:0]   trialSub;
  logic [WIDTH+1:0] diff;

  // Busy includes the launch cycle, which only loads
  assign step = busy & ~link.launch;

  //////////////////////////////
  // One radix-2 step
  //////////////////////////////

  always_comb begin
    if (opReg == divSqrtPkg::OP_SQRT) begin
      // Bring in the next bit pair and try to subtract 4*root+1
      trialRem = {remReg[WIDTH-2:0], dvdReg[WIDTH-1:WIDTH-2]};
      trialSub = {quoReg[WIDTH-2:0], 2'b01};
      dvdNext  = {dvdReg[WIDTH-3:0], 2'b00};
    end else begin
      // Bring in the next dividend bit and try to subtract the divisor
      trialRem = {remReg[WIDTH-1:0], dvdReg[WIDTH-1]};
      trialSub = {1'b0, dvsReg};
      dvdNext  = {dvdReg[WIDTH-2:0], 1'b0};
    end
    diff = {1'b0, trialRem} - {1'b0, trialSub};
    // Negative difference restores the old partial remainder
    if (diff[WIDTH+1]) begin
      remNext = trialRem;
      quoNext = {quoReg[WIDTH-2:0], 1'b0};
    end else begin
      remNext = diff[WIDTH:0];
      quoNext = {quoReg[WIDTH-2:0], 1'b1};
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (link.launch) begin
      remReg <= '0;
      quoReg <= '0;
      dvdReg <= link.normX;
      dvsReg <= link.normY;
      opReg  <= link.op;
    end else if (step) begin
      remReg <= remNext;
      quoReg <= quoNext;
      dvdReg <= dvdNext;
    end
  end

  // Own copy of the count so finish lines up with the last step
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (link.launch) begin
      cnt <= link.cycles;
    end else if (step && cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign finish    = step & (cnt == CNT_W'(1));
  assign quotient  = quoNext;
  // Final remainders are below the divisor or at most twice the root
  assign remainder = remNext[WIDTH-1:0];

  // Restoring division keeps the partial remainder below the divisor
  divRemBelowDivisor: assert property (
    @(posedge clk) disable iff (rst)
    step && opReg == divSqrtPkg::OP_DIV |-> remReg < {1'b0, dvsReg}
  );

endmodule

/* design/divSqrtPostproc.sv */
// Consumer stage that presents the final quotient and remainder
// Special results are written on the launch edge, iterated ones on the edge
// that ends the finish pulse, so both are valid when done rises
// Results hold until the next operation writes them

`timescale 1ns/1ps

module divSqrtPostproc #(
  parameter int WIDTH = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                launch,
  input  divSqrtPkg::specialT special,
  input  logic [WIDTH-1:0]    quotient,
  input  logic [WIDTH-1:0]    remainder,
  input  logic                finish,
  input  logic [WIDTH-1:0]    x,
  output logic [WIDTH-1:0]    resultQ,
  output logic [WIDTH-1:0]    resultR,
  output logic                specialCase,
  output logic                divByZero
);

  // Kind of the operation currently presented
  divSqrtPkg::specialT spcKind;

  always_ff @(posedge clk) begin
    if (rst) begin
      spcKind <= divSqrtPkg::SPC_NONE;
      resultQ <= '0;
      resultR <= '0;
    end else if (launch) begin
      spcKind <= special;
      // Fixed results need no iteration
      case (special)
        divSqrtPkg::SPC_ZERO: begin
          resultQ <= '0;
          resultR <= '0;
        end
        divSqrtPkg::SPC_DIVZERO: begin
          // All ones quotient and the untouched dividend as remainder
          resultQ <= '1;
          resultR <= x;
        end
        default: begin
          // Normal case keeps the old result until finish
        end
      endcase
    end else if (finish) begin
      resultQ <= quotient;
      resultR <= remainder;
    end
  end

  assign specialCase = (spcKind != divSqrtPkg::SPC_NONE);
  assign divByZero   = (spcKind == divSqrtPkg::SPC_DIVZERO);

  // The buffer only iterates for normal operations
  finishOnlyNormal: assert property (
    @(posedge clk) disable iff (rst)
    finish |-> spcKind == divSqrtPkg::SPC_NONE
  );

endmodule

/* design/divSqrtUnit.sv */
// Iterative unsigned divide and integer square root unit
// One operation in flight, start is taken only when idle and not stalled
// Results are valid while done is high and hold until the next done
// WIDTH must be even, from 8 to 32

`timescale 1ns/1ps

module divSqrtUnit #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             sqrt,
  input  logic             stall,
  input  logic             flush,
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  output logic             busy,
  output logic             done,
  output logic             specialCase,
  output logic             divByZero,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);

  // Buffer to consumer path
  logic [WIDTH-1:0] iterQ;
  logic [WIDTH-1:0] iterR;
  logic             iterFinish;

  divSqrtIf #(.WIDTH(WIDTH)) link ();

  //////////////////////////////
  // Stages
  //////////////////////////////

  divSqrtPreproc #(.WIDTH(WIDTH)) u_preproc (
    .x(x), .y(y), .sqrt(sqrt), .link(link.pre)
  );

  divSqrtFsm #(.WIDTH(WIDTH)) u_fsm (
    .clk(clk), .rst(rst), .start(start), .stall(stall), .flush(flush),
    .link(link.ctl), .busy(busy), .done(done)
  );

  divSqrtIter #(.WIDTH(WIDTH)) u_iter (
    .clk(clk), .rst(rst), .busy(busy), .link(link.iter),
    .quotient(iterQ), .remainder(iterR), .finish(iterFinish)
  );

  divSqrtPostproc #(.WIDTH(WIDTH)) u_postproc (
    .clk(clk), .rst(rst), .launch(link.launch), .special(link.special),
    .quotient(iterQ), .remainder(iterR), .finish(iterFinish), .x(x),
    .resultQ(quotient), .resultR(remainder),
    .specialCase(specialCase), .divByZero(divByZero)
  );

endmodule

/* sim/divSqrtTb.sv */
// Testbench for the divide and square root unit at WIDTH 16
// Concurrent assertions compare the outputs with a reference model that is set
// up before every launch
// The stimulus tasks only steer the unit into the situations the assertions watch
// Only one operation is driven at a time and x stays stable until the next one
// The square root model loops up to the root, so it is meant for small widths

`timescale 1ns/1ps

module divSqrtTb;

  localparam int WIDTH         = 16;
  localparam int CLK_PERIOD    = 8;
  localparam int NUM_RAND_DIV  = 200;
  localparam int NUM_RAND_SQRT = 60;
  // Random operations plus the directed, stall and flush ones
  localparam int NUM_OPS       = NUM_RAND_DIV + NUM_RAND_SQRT + 40;
  localparam int TIMEOUT_NS    = NUM_OPS * (WIDTH + 8) * CLK_PERIOD + 5000;

  logic             clk = 1'b0;
  logic             rst;
  logic             start;
  logic             sqrt;
  logic             stall;
  logic             flush;
  logic [WIDTH-1:0] x;
  logic [WIDTH-1:0] y;
  logic             busy;
  logic             done;
  logic             specialCase;
  logic             divByZero;
  logic [WIDTH-1:0] quotient;
  logic [WIDTH-1:0] remainder;

  // Reference results for the operation in flight
  logic [WIDTH-1:0] expQ = '0;
  logic [WIDTH-1:0] expR = '0;
  logic             expSpecial = 1'b0;
  logic             expDivZero = 1'b0;
  logic [7:0]       expLat = 8'd0;
  // Edges seen since start was driven, and a flushed op still pending
  logic [7:0]       edgeCnt;
  logic             flushPend;
  int               valueErrs = 0;
  int               protoErrs = 0;

  divSqrtUnit #(.WIDTH(WIDTH)) u_divSqrtUnit (
    .clk(clk), .rst(rst), .start(start), .sqrt(sqrt), .stall(stall), .flush(flush),
    .x(x), .y(y), .busy(busy), .done(done), .specialCase(specialCase),
    .divByZero(divByZero), .quotient(quotient), .remainder(remainder)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // The launch cycle is the only one where start and busy are high together
  always @(posedge clk) begin
    if (rst) begin
      edgeCnt   <= 8'd0;
      flushPend <= 1'b0;
    end else begin
      if (start && busy) edgeCnt <= 8'd1;
      else if (edgeCnt != 8'hff) edgeCnt <= edgeCnt + 8'd1;
      if (flush) flushPend <= 1'b1;
      else if (start && busy) flushPend <= 1'b0;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic computeExpected(input logic isSqrt, input logic [WIDTH-1:0] a,
                                 input logic [WIDTH-1:0] b);
    int n;
    int r;
    int cyc;
    n = 0;
    for (int i = 0; i < WIDTH; i++) begin
      if (a[i]) n = i + 1;
    end
    // Square root takes bit pairs, so half the bits rounded up
    cyc = isSqrt ? (n + 1) / 2 : n;
    expSpecial = 1'b0;
    expDivZero = 1'b0;
    if (a == '0) begin
      expSpecial = 1'b1;
      expQ = '0;
      expR = '0;
    end else if (!isSqrt && b == '0) begin
      expSpecial = 1'b1;
      expDivZero = 1'b1;
      expQ = '1;
      expR = a;
    end else if (isSqrt) begin
      r = 0;
      while ((r + 1) * (r + 1) <= a) r++;
      expQ = WIDTH'(r);
      expR = a - WIDTH'(r * r);
    end else begin
      expQ = a / b;
      expR = a % b;
    end
    expLat = expSpecial ? 8'd1 : 8'(cyc + 1);
  endtask

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Called and returns on a falling edge with the unit idle
  task automatic runOp(input logic isSqrt, input logic [WIDTH-1:0] a,
                       input logic [WIDTH-1:0] b, input int holdCycles);
    computeExpected(isSqrt, a, b);
    sqrt  = isSqrt;
    x     = a;
    y     = b;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    // Raising stall after launch holds DONE once it comes
    if (holdCycles > 0) stall = 1'b1;
    while (!done) @(negedge clk);
    repeat (holdCycles) @(negedge clk);
    stall = 1'b0;
    while (done) @(negedge clk);
  endtask

  task automatic startWhileStalled();
    stall = 1'b1;
    sqrt  = 1'b0;
    x     = WIDTH'(100);
    y     = WIDTH'(7);
    start = 1'b1;
    repeat (3) @(negedge clk);
    start = 1'b0;
    @(negedge clk);
    stall = 1'b0;
    @(negedge clk);
  endtask

  // Flush a few steps into a long operation and wait long enough for a stray done
  task automatic flushMidOp(input logic isSqrt, input logic [WIDTH-1:0] a,
                            input logic [WIDTH-1:0] b);
    sqrt  = isSqrt;
    x     = a;
    y     = b;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (3) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    repeat (WIDTH + 4) @(negedge clk);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  quotientOk: assert property (@(posedge clk) disable iff (rst) done |-> quotient == expQ)
    else begin
      valueErrs++;
      $display("FAIL quotient exp=0x%h got=0x%h", expQ, $sampled(quotient));
    end

  remainderOk: assert property (@(posedge clk) disable iff (rst) done |-> remainder == expR)
    else begin
      valueErrs++;
      $display("FAIL remainder exp=0x%h got=0x%h", expR, $sampled(remainder));
    end

  specialOk: assert property (@(posedge clk) disable iff (rst)
    done |-> specialCase == expSpecial)
    else begin
      valueErrs++;
      $display("FAIL specialCase exp=0x%h got=0x%h", expSpecial, $sampled(specialCase));
    end

  divZeroOk: assert property (@(posedge clk) disable iff (rst)
    done |-> divByZero == expDivZero)
    else begin
      valueErrs++;
      $display("FAIL divByZero exp=0x%h got=0x%h", expDivZero, $sampled(divByZero));
    end

  // Done must appear exactly cycles+1 edges after launch and one edge after a special launch
  latencyOk: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> edgeCnt == expLat)
    else begin
      protoErrs++;
      $display("Error: done rose %0d edges after start instead of %0d",
               $sampled(edgeCnt), expLat);
    end

  busyUntilDone: assert property (@(posedge clk) disable iff (rst)
    busy && !flush |=> busy || done)
    else begin
      protoErrs++;
      $display("Error: busy dropped before the operation reached done");
    end

  doneNotBusy: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
    else begin
      protoErrs++;
      $display("Error: busy and done were high together");
    end

  doneOneCycle: assert property (@(posedge clk) disable iff (rst)
    done && !stall |=> !done)
    else begin
      protoErrs++;
      $display("Error: done stayed high although stall was low");
    end

  stallBlocksStart: assert property (@(posedge clk) disable iff (rst)
    start && stall |-> !busy)
    else begin
      protoErrs++;
      $display("Error: start was accepted while stall was high");
    end

  stallHoldsDone: assert property (@(posedge clk) disable iff (rst)
    done && stall |=> done && $stable(quotient) && $stable(remainder))
    else begin
      protoErrs++;
      $display("Error: done or the result changed while stall was high");
    end

  // The result may only change on the edge where a new done rises
  resultHeld: assert property (@(posedge clk) disable iff (rst)
    !$rose(done) |-> $stable(quotient) && $stable(remainder))
    else begin
      protoErrs++;
      $display("Error: the result changed without a new done");
    end

  flushNoDone: assert property (@(posedge clk) disable iff (rst) flushPend |-> !done)
    else begin
      protoErrs++;
      $display("Error: a flushed operation raised done");
    end

  resetClean: assert property (@(posedge clk)
    $fell(rst) |-> !done && !busy && quotient == '0 && remainder == '0 &&
                   !specialCase && !divByZero)
    else begin
      protoErrs++;
      $display("Error: outputs were not cleared by reset");
    end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    void'($urandom(32'h724e));
    rst   = 1'b1;
    start = 1'b0;
    sqrt  = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    x     = '0;
    y     = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Division edge operands including a divisor above the dividend
    runOp(1'b0, WIDTH'(1), WIDTH'(1), 0);
    runOp(1'b0, '1, WIDTH'(1), 0);
    runOp(1'b0, '1, '1, 0);
    runOp(1'b0, WIDTH'(5), WIDTH'(9), 0);
    runOp(1'b0, '1, WIDTH'(3), 0);
    runOp(1'b0, WIDTH'(1), '1, 0);
    runOp(1'b0, WIDTH'(16'h8000), WIDTH'(16'h00ff), 0);
    for (int i = 0; i < NUM_RAND_DIV; i++) begin
      a = WIDTH'($urandom);
      // Shifting the divisor by a random amount spreads its size
      b = WIDTH'($urandom) >> ($urandom % WIDTH);
      runOp(1'b0, a, b, 0);
    end

    // Perfect squares, odd and even bit counts, and all ones
    for (int i = 0; i < WIDTH; i++) begin
      runOp(1'b1, WIDTH'((i + 1) * (i + 1)), '0, 0);
    end
    runOp(1'b1, WIDTH'(2), '0, 0);
    runOp(1'b1, WIDTH'(3), '0, 0);
    runOp(1'b1, '1, '0, 0);
    for (int i = 0; i < NUM_RAND_SQRT; i++) begin
      a = WIDTH'($urandom) >> ($urandom % WIDTH);
      runOp(1'b1, a, '0, 0);
    end

    // Special cases finish one edge after launch
    runOp(1'b0, '0, WIDTH'(5), 0);
    runOp(1'b0, '0, '0, 0);
    runOp(1'b1, '0, '0, 0);
    runOp(1'b0, WIDTH'(123), '0, 0);

    // Back-pressure on launch and on done
    startWhileStalled();
    runOp(1'b0, WIDTH'(16'hbeef), WIDTH'(13), 5);
    runOp(1'b0, WIDTH'(77), '0, 4);
    runOp(1'b1, WIDTH'(16'h4000), '0, 3);

    // Flushed work must vanish and the next operation must be clean
    flushMidOp(1'b0, WIDTH'(16'hf0f0), WIDTH'(7));
    runOp(1'b0, WIDTH'(16'h1234), WIDTH'(10), 0);
    flushMidOp(1'b1, '1, '0);
    runOp(1'b1, WIDTH'(16'h9c40), '0, 0);

    repeat (4) @(negedge clk);
    $display("Errors: %0d value, %0d protocol", valueErrs, protoErrs);
    if (valueErrs == 0 && protoErrs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog sized from the operation count and the worst case length
  initial begin
    #(TIMEOUT_NS);
    $display("Error: watchdog timeout after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* divSqrt.f */
design/divSqrtPkg.sv
design/divSqrtIf.sv
design/divSqrtPreproc.sv
design/divSqrtFsm.sv
design/divSqrtIter.sv
design/divSqrtPostproc.sv
design/divSqrtUnit.sv
sim/divSqrtTb.sv

/* Makefile */
TOP := divSqrtTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f divSqrt.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
